// File: hw/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// widths shared by both packages
`define WORD_W      32
`define EXC_CODE_W  5
`define CP0_SEL_W   5

// general exception vector, kseg0 with BEV clear
`define EXC_ENTRY   32'h8000_0180

// cp0 register numbers, select 0
`define CP0_REG_BADVADDR  5'd8
`define CP0_REG_STATUS    5'd12
`define CP0_REG_CAUSE     5'd13
`define CP0_REG_EPC       5'd14

// status bit positions
`define STATUS_IE_BIT   0
`define STATUS_EXL_BIT  1
`define STATUS_ERL_BIT  2
`define STATUS_IM_LSB   8

// cause bit positions
`define CAUSE_IP_LSB    8

// status after reset, only ERL set
`define CP0_STATUS_RESET  (32'h1 << `STATUS_ERL_BIT)

// software-writable status bits: IM, ERL, EXL, IE
`define STATUS_WMASK  ((32'hff << `STATUS_IM_LSB) | \
                       (32'h1 << `STATUS_ERL_BIT) | \
                       (32'h1 << `STATUS_EXL_BIT) | \
                       (32'h1 << `STATUS_IE_BIT))

// only the two software interrupt bits IP1 and IP0
`define CAUSE_WMASK   (32'h3 << `CAUSE_IP_LSB)

`endif

// File: hw/cpu_types_pkg.sv
`include "mips_defs.svh"

package cpu_types_pkg;

    // data or address word
    typedef logic [`WORD_W-1:0] word_t;

    // one bit per condition seen by the pipeline
    // listed in commit priority order, highest first
    typedef struct packed {
        // fetch address error
        logic instr;
        // fetch tlb miss
        logic instr_tlb;
        // coprocessor unusable
        logic cpu;
        // reserved instruction
        logic ri;
        // arithmetic overflow
        logic of;
        logic bp;
        logic sys;
        // trap instruction
        logic tr;
        // data address errors
        logic load;
        logic save;
        // data tlb misses
        logic load_tlb;
        logic save_tlb;
        // store to clean page
        logic mod;
    } exc_flags_t;

    // mips ExcCode field values
    typedef enum logic [`EXC_CODE_W-1:0] {
        code_int  = 5'd0,
        code_mod  = 5'd1,
        code_tlbl = 5'd2,
        code_tlbs = 5'd3,
        code_adel = 5'd4,
        code_ades = 5'd5,
        code_sys  = 5'd8,
        code_bp   = 5'd9,
        code_ri   = 5'd10,
        code_cpu  = 5'd11,
        code_ov   = 5'd12,
        code_tr   = 5'd13
    } exc_code_t;

endpackage

// File: hw/cp0_pkg.sv
`include "mips_defs.svh"

package cp0_pkg;

    // status register, bit 0 on the right
    typedef struct packed {
        // 31:16 not implemented
        logic [15:0] zero_hi;
        // interrupt mask, one per IP bit
        logic [7:0]  IM;
        // 7:3 not implemented (no user mode here)
        logic [4:0]  zero_lo;
        logic        ERL;
        logic        EXL;
        logic        IE;
    } cp0_status_t;

    // cause register
    typedef struct packed {
        // last exception was in a branch delay slot
        logic                     BD;
        logic [14:0]              zero_hi;
        // pending lines, 7:2 hardware and 1:0 software
        logic [7:0]               IP;
        logic                     zero_mid;
        cpu_types_pkg::exc_code_t ExcCode;
        logic [1:0]               zero_lo;
    } cp0_cause_t;

    // registers reachable from the access port
    // values match the mfc0/mtc0 rd field
    typedef enum logic [`CP0_SEL_W-1:0] {
        reg_badvaddr = `CP0_REG_BADVADDR,
        reg_status   = `CP0_REG_STATUS,
        reg_cause    = `CP0_REG_CAUSE,
        reg_epc      = `CP0_REG_EPC
    } cp0_reg_t;

endpackage

// File: hw/exc_commit_if.sv
`timescale 1ns/1ps

interface exc_commit_if;
    import cpu_types_pkg::*;
    import cp0_pkg::*;

    // committed exception, one-cycle strobe
    logic        valid;
    exc_code_t   code;
    word_t       pc;
    logic        in_delay_slot;
    logic        badvaddr_we;
    word_t       badvaddr;
    // committed eret, one-cycle strobe
    logic        eret;
    // fed back from the register file
    cp0_status_t status;
    // IP masked by IM
    logic [7:0]  pending;

    modport master (
        output valid, code, pc, in_delay_slot, badvaddr_we, badvaddr, eret,
        input  status, pending
    );

    modport slave (
        input  valid, code, pc, in_delay_slot, badvaddr_we, badvaddr, eret,
        output status, pending
    );

endinterface

// File: hw/exception.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module exception (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  cpu_types_pkg::exc_flags_t flags,
    input  cpu_types_pkg::word_t      pc,
    input  cpu_types_pkg::word_t      vaddr,
    input  logic                      in_delay_slot,
    input  logic                      eret,
    input  cpu_types_pkg::word_t      epc,
    output logic                      redirect_valid,
    output cpu_types_pkg::word_t      redirect_pc,
    exc_commit_if.master              commit
);
    import cpu_types_pkg::*;

    logic      int_valid;
    logic      flag_valid;
    logic      exc_any;
    exc_code_t flag_code;
    exc_code_t code;
    logic      eret_q;

    // interrupt needs a pending line, IE, and no exception level
    assign int_valid = (|commit.pending)
                     & commit.status.IE
                     & ~commit.status.EXL
                     & ~commit.status.ERL;

    // instruction-side flags only count with a real instruction
    assign flag_valid = instr_valid & (|flags);

    // first set flag wins
    always_comb begin
        priority case (1'b1)
            flags.instr:     flag_code = code_adel;
            flags.instr_tlb: flag_code = code_tlbl;
            flags.cpu:       flag_code = code_cpu;
            flags.ri:        flag_code = code_ri;
            flags.of:        flag_code = code_ov;
            flags.bp:        flag_code = code_bp;
            flags.sys:       flag_code = code_sys;
            flags.tr:        flag_code = code_tr;
            flags.load:      flag_code = code_adel;
            flags.save:      flag_code = code_ades;
            flags.load_tlb:  flag_code = code_tlbl;
            flags.save_tlb:  flag_code = code_tlbs;
            flags.mod:       flag_code = code_mod;
            default:         flag_code = code_int;
        endcase
    end

    // interrupt sits above every flag
    assign code    = int_valid ? code_int : flag_code;
    assign exc_any = int_valid | flag_valid;

    assign commit.valid         = exc_any & rst_n;
    assign commit.code          = code;
    assign commit.pc            = pc;
    assign commit.in_delay_slot = in_delay_slot;
    assign commit.badvaddr      = vaddr;
    // address and tlb faults report the faulting address
    assign commit.badvaddr_we   = commit.valid
                                & (code inside {code_adel, code_ades,
                                                code_tlbl, code_tlbs, code_mod});

    // an eret loses to any exception in the same slot
    // eret_q drops a repeat strobe right after a taken eret,
    // the redirected fetch cannot have delivered a new one yet
    assign commit.eret = eret & instr_valid & ~exc_any & ~eret_q & rst_n;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            eret_q <= 1'b0;
        end else begin
            eret_q <= commit.eret;
        end
    end

    // fetch redirect, exception vector first
    assign redirect_valid = commit.valid | commit.eret;
    assign redirect_pc    = commit.valid ? `EXC_ENTRY : epc;

endmodule

// File: hw/cp0_regs.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module cp0_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [5:0]             ext_int,
    input  logic                   acc_req,
    input  logic                   acc_we,
    input  cp0_pkg::cp0_reg_t      acc_sel,
    input  cpu_types_pkg::word_t   acc_wdata,
    output logic                   acc_ack,
    output cpu_types_pkg::word_t   acc_rdata,
    output cpu_types_pkg::word_t   epc,
    exc_commit_if.slave            commit
);
    import cpu_types_pkg::*;
    import cp0_pkg::*;

    cp0_status_t status_q;
    cp0_status_t status_nxt;
    cp0_cause_t  cause_q;
    cp0_cause_t  cause_nxt;
    word_t       epc_q;
    word_t       badvaddr_q;
    word_t       rd_data;
    logic        acc_ack_q;
    logic        acc_fire;
    logic        wr_status;
    logic        wr_cause;
    logic        wr_epc;
    logic        epc_load;

    // access happens once, on the first edge of a new request
    assign acc_fire  = acc_req & ~acc_ack_q;
    assign wr_status = acc_fire & acc_we & (acc_sel == reg_status);
    assign wr_cause  = acc_fire & acc_we & (acc_sel == reg_cause);
    assign wr_epc    = acc_fire & acc_we & (acc_sel == reg_epc);

    // EPC and BD only move on the first exception level
    assign epc_load = commit.valid & ~status_q.EXL;

    // status next state
    always_comb begin
        status_nxt = status_q;
        if (wr_status) begin
            status_nxt = cp0_status_t'((status_q & ~`STATUS_WMASK)
                                     | (acc_wdata & `STATUS_WMASK));
        end
        // commit overrides a software write to the same field
        if (commit.valid) begin
            status_nxt.EXL = 1'b1;
        end else if (commit.eret) begin
            // error level unwinds before exception level
            if (status_q.ERL) begin
                status_nxt.ERL = 1'b0;
            end else begin
                status_nxt.EXL = 1'b0;
            end
        end
    end

    // cause next state
    always_comb begin
        cause_nxt = cause_q;
        if (wr_cause) begin
            cause_nxt = cp0_cause_t'((cause_q & ~`CAUSE_WMASK)
                                   | (acc_wdata & `CAUSE_WMASK));
        end
        // hardware lines sampled every cycle
        cause_nxt.IP[7:2] = ext_int;
        if (commit.valid) begin
            cause_nxt.ExcCode = commit.code;
            if (epc_load) begin
                cause_nxt.BD = commit.in_delay_slot;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q   <= cp0_status_t'(`CP0_STATUS_RESET);
            cause_q    <= '0;
            epc_q      <= '0;
            badvaddr_q <= '0;
        end else begin
            status_q <= status_nxt;
            cause_q  <= cause_nxt;
            // restart address, back up to the branch in a delay slot
            if (epc_load) begin
                epc_q <= commit.in_delay_slot ? commit.pc - 32'd4 : commit.pc;
            end else if (wr_epc) begin
                epc_q <= acc_wdata;
            end
            // read-only to software
            if (commit.badvaddr_we) begin
                badvaddr_q <= commit.badvaddr;
            end
        end
    end

    // read mux
    always_comb begin
        case (acc_sel)
            reg_badvaddr: rd_data = badvaddr_q;
            reg_status:   rd_data = status_q;
            reg_cause:    rd_data = cause_q;
            reg_epc:      rd_data = epc_q;
            default:      rd_data = '0;
        endcase
    end

    // four-phase handshake
    // ack rises with the access, falls the edge after req drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_ack_q <= 1'b0;
        end else if (acc_fire) begin
            acc_ack_q <= 1'b1;
        end else if (!acc_req) begin
            acc_ack_q <= 1'b0;
        end
    end

    // read data held until the next read
    always_ff @(posedge clk) begin
        if (acc_fire && !acc_we) begin
            acc_rdata <= rd_data;
        end
    end

    assign acc_ack = acc_ack_q;
    assign epc     = epc_q;

    // feedback to the priority block
    assign commit.status  = status_q;
    assign commit.pending = cause_q.IP & status_q.IM;

endmodule

// File: hw/exc_subsys_top.sv
`timescale 1ns/1ps

module exc_subsys_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [5:0]                 ext_int,
    // memory stage
    input  logic                       instr_valid,
    input  cpu_types_pkg::exc_flags_t  flags,
    input  cpu_types_pkg::word_t       pc,
    input  cpu_types_pkg::word_t       vaddr,
    input  logic                       in_delay_slot,
    input  logic                       eret,
    // cp0 access port
    input  logic                       acc_req,
    input  logic                       acc_we,
    input  cp0_pkg::cp0_reg_t          acc_sel,
    input  cpu_types_pkg::word_t       acc_wdata,
    output logic                       acc_ack,
    output cpu_types_pkg::word_t       acc_rdata,
    // commit and fetch control
    output logic                       exc_valid,
    output cpu_types_pkg::exc_code_t   exc_code,
    output logic                       redirect_valid,
    output cpu_types_pkg::word_t       redirect_pc
);
    import cpu_types_pkg::*;

    // stored restart address for eret
    word_t epc;

    exc_commit_if commit_if ();

    exception exception_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .flags          (flags),
        .pc             (pc),
        .vaddr          (vaddr),
        .in_delay_slot  (in_delay_slot),
        .eret           (eret),
        .epc            (epc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .commit         (commit_if.master)
    );

    cp0_regs cp0_regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ext_int   (ext_int),
        .acc_req   (acc_req),
        .acc_we    (acc_we),
        .acc_sel   (acc_sel),
        .acc_wdata (acc_wdata),
        .acc_ack   (acc_ack),
        .acc_rdata (acc_rdata),
        .epc       (epc),
        .commit    (commit_if.slave)
    );

    // pipeline sees the same strobe the register file acts on
    assign exc_valid = commit_if.valid;
    assign exc_code  = commit_if.code;

endmodule

// File: dv/tb_exc_subsys.sv
`timescale 1ns/1ps

module tb_exc_subsys;
    import cpu_types_pkg::*;
    import cp0_pkg::*;

    // cycles allowed for each acc_ack edge
    localparam int ACK_TIMEOUT = 40;

    logic       clk;
    logic       rst_n;
    logic [5:0] ext_int;
    logic       instr_valid;
    exc_flags_t flags;
    word_t      pc;
    word_t      vaddr;
    logic       in_delay_slot;
    logic       eret;
    logic       acc_req;
    logic       acc_we;
    cp0_reg_t   acc_sel;
    word_t      acc_wdata;
    logic       acc_ack;
    word_t      acc_rdata;
    logic       exc_valid;
    exc_code_t  exc_code;
    logic       redirect_valid;
    word_t      redirect_pc;

    int   value_errs = 0;
    int   other_errs = 0;
    int   checks = 0;
    logic timed_out = 1'b0;

    exc_subsys_top exc_subsys_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %s: got 0x%08h, expected 0x%08h (t=%0t)", name, got, exp, $time);
            value_errs++;
        end
    endtask

    // a short line would leave stale fields from the previous step
    function automatic bit field_count_ok(input int got, input int want, input string what);
        if (got != want) begin
            $display("stimulus step %s has %0d fields, expected %0d",
                     what, got, want);
            other_errs++;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // code and pc only matter when the strobe is expected
    task automatic check_outputs(input logic [31:0] ev, ec, erv, erpc);
        check_value("exc_valid", 32'(exc_valid), ev);
        if (ev != 0) begin
            check_value("exc_code", 32'(exc_code), ec);
        end
        check_value("redirect_valid", 32'(redirect_valid), erv);
        if (erv != 0) begin
            check_value("redirect_pc", redirect_pc, erpc);
        end
    endtask

    // poll acc_ack on falling edges until it reaches level
    task automatic wait_ack(input logic level, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (acc_ack !== level && n < ACK_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (acc_ack !== level) begin
            $display("timeout: acc_ack did not %s within %0d cycles", what, ACK_TIMEOUT);
            other_errs++;
            timed_out = 1'b1;
        end
    endtask

    task automatic commit_step(input logic [31:0] iv, fl, p, va, ds, er,
                               input logic [31:0] ev, ec, erv, erpc);
        @(posedge clk);
        instr_valid   <= iv[0];
        flags         <= exc_flags_t'(fl[12:0]);
        pc            <= p;
        vaddr         <= va;
        in_delay_slot <= ds[0];
        eret          <= er[0];
        // commit path is combinational
        @(negedge clk);
        check_outputs(ev, ec, erv, erpc);
        @(posedge clk);
        // pc is held so an idle interrupt saves it as EPC
        instr_valid   <= 1'b0;
        flags         <= '0;
        in_delay_slot <= 1'b0;
        eret          <= 1'b0;
        @(negedge clk);
    endtask

    task automatic access_step(input logic we, input logic [31:0] sel, data);
        @(posedge clk);
        acc_req   <= 1'b1;
        acc_we    <= we;
        acc_sel   <= cp0_reg_t'(sel[4:0]);
        acc_wdata <= data;
        wait_ack(1'b1, "rise");
        if (!timed_out) begin
            if (!we) begin
                check_value("acc_rdata", acc_rdata, data);
            end
            @(posedge clk);
            acc_req <= 1'b0;
            // ack holds through the edge where req drops
            @(negedge clk);
            check_value("acc_ack", 32'(acc_ack), 32'h1);
            wait_ack(1'b0, "fall");
        end
    endtask

    task automatic int_step(input logic [31:0] lines, ev, ec, erv, erpc);
        @(posedge clk);
        ext_int <= lines[5:0];
        // cause.IP picks the lines up one edge later
        @(posedge clk);
        @(negedge clk);
        check_outputs(ev, ec, erv, erpc);
    endtask

    initial begin
        int               fd;
        int               n;
        string            op;
        logic [31:0]      f [0:9];
        logic [8*128-1:0] rest;
        rst_n         = 1'b0;
        ext_int       = '0;
        instr_valid   = 1'b0;
        flags         = '0;
        pc            = '0;
        vaddr         = '0;
        in_delay_slot = 1'b0;
        eret          = 1'b0;
        acc_req       = 1'b0;
        acc_we        = 1'b0;
        acc_sel       = reg_status;
        acc_wdata     = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("acc_ack", 32'(acc_ack), 32'h0);
        fd = $fopen("dv/exc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/exc_stimulus.txt");
            other_errs++;
        end else begin
            while (!timed_out && $fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    void'($fgets(rest, fd));
                end else if (op == "cm") begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    if (field_count_ok(n, 10, op)) begin
                        commit_step(f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                    f[8], f[9]);
                    end
                end else if (op == "int") begin
                    n = $fscanf(fd, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                    if (field_count_ok(n, 5, op)) begin
                        int_step(f[0], f[1], f[2], f[3], f[4]);
                    end
                end else if (op == "chk") begin
                    n = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                    if (field_count_ok(n, 4, op)) begin
                        check_outputs(f[0], f[1], f[2], f[3]);
                    end
                end else if (op == "wr" || op == "rd") begin
                    n = $fscanf(fd, "%h %h", f[0], f[1]);
                    if (field_count_ok(n, 2, op)) begin
                        access_step(op == "wr", f[0], f[1]);
                    end
                end else begin
                    $display("unknown step %s in stimulus file", op);
                    other_errs++;
                end
            end
            $fclose(fd);
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: dv/exc_stimulus.txt
# cm iv flags pc vaddr ds eret, then exc_valid exc_code redirect_valid redirect_pc
# chk and int (ext_int first) carry the same four outputs; wr sel wdata, rd sel rdata
chk 0 0 0 0
rd 0c 00000004
rd 0d 00000000
cm 0 1fff 00400000 00000000 0 0 0 0 0 0
cm 1 0010 00400100 12345679 0 0 1 04 1 80000180
rd 0e 00400100
rd 08 12345679
rd 0d 00000010
cm 1 0040 00400200 deadbeef 1 0 1 08 1 80000180
rd 0e 00400100
rd 08 12345679
wr 0c 00000000
cm 1 0002 00400300 0badf00c 1 0 1 03 1 80000180
rd 0e 004002fc
rd 0d 8000000c
cm 1 1fff 00400400 00000000 0 0 1 04 1 80000180
cm 1 0fff 00400400 00000000 0 0 1 02 1 80000180
cm 1 07ff 00400400 00000000 0 0 1 0b 1 80000180
cm 1 03ff 00400400 00000000 0 0 1 0a 1 80000180
cm 1 01ff 00400400 00000000 0 0 1 0c 1 80000180
cm 1 00ff 00400400 00000000 0 0 1 09 1 80000180
cm 1 007f 00400400 00000000 0 0 1 08 1 80000180
cm 1 003f 00400400 00000000 0 0 1 0d 1 80000180
cm 1 000f 00400400 00000000 0 0 1 05 1 80000180
cm 1 0241 00400400 00000000 0 0 1 0a 1 80000180
cm 1 0001 00400400 00001000 0 0 1 01 1 80000180
rd 08 00001000
rd 0e 004002fc
cm 1 0000 00400500 00000000 0 1 0 0 1 004002fc
wr 0c 00000401
int 02 0 0 0 0
int 01 1 00 1 80000180
rd 0e 00400500
chk 0 0 0 0
int 00 0 0 0 0
cm 1 0000 00400600 00000000 0 1 0 0 1 00400500
wr 0c 00000400
int 01 0 0 0 0
wr 0c 00000405
chk 0 0 0 0
int 00 0 0 0 0
wr 0c 00000103
wr 0d 00000100
chk 0 0 0 0
wr 0e 00400700
cm 1 0000 00400800 00000000 0 1 0 0 1 00400700
chk 1 00 1 80000180
rd 0e 00400800
rd 0c 00000103
rd 0d 00000100

// File: flist.f
+incdir+hw
hw/cpu_types_pkg.sv
hw/cp0_pkg.sv
hw/exc_commit_if.sv
hw/exception.sv
hw/cp0_regs.sv
hw/exc_subsys_top.sv
dv/tb_exc_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the exception subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
    --top-module tb_exc_subsys -o sim_exc
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_exc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1
